// ==== verilog.f ====
core_pkg.sv
ctrl_stream_if.sv
settings_if.sv
ctrl_sid_filter.sv
ctrl_proc.sv
core_settings.sv
pps_select.sv
core_top.sv
tb_clock_gen.sv
core_assert.sv
core_tb.sv

// ==== core_tb.sv ====
////////////////////////////////////////
// control plane testbench
// table of requests, response checks, PPS checks
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module core_tb;
   import core_pkg::*;

   typedef struct packed {
      logic [7:0]  dst_sid;
      logic [7:0]  src_sid;
      logic [11:0] seqnum;
      logic [7:0]  addr;
      logic [31:0] data;
      logic        resp_exp;
      logic        extra;
      logic [63:0] exp_rb;
   } req_row_t;

   logic                  radio_clk;
   logic                  bus_rst;
   logic [ctrl_width-1:0] i_ctrl_tdata;
   logic                  i_ctrl_tlast;
   logic                  i_ctrl_tvalid;
   logic                  o_ctrl_tready;
   logic [ctrl_width-1:0] o_resp_tdata;
   logic                  o_resp_tlast;
   logic                  o_resp_tvalid;
   logic                  i_resp_tready;
   logic [31:0]           i_rb_misc;
   logic [1:0]            i_lock;
   logic                  i_pps_int;
   logic                  i_pps_ext;
   logic [31:0]           o_misc_outs;
   logic                  o_pps;
   logic                  o_time_sync;

   req_row_t    rows[$];
   logic [64:0] exp_q[$];
   logic [64:0] exp_word;
   logic [31:0] misc_model;
   logic [63:0] sig_word;
   logic [63:0] misc1_word;
   logic [63:0] misc2_word;
   logic [63:0] gps_word;
   logic [63:0] lock_word;
   int          row_idx;
   int          cycle_limit;
   int          cycle_count = 0;

   tb_clock_gen clk_gen_i (.radio_clk(radio_clk), .bus_rst(bus_rst));

   core_top dut_i (
      .radio_clk (radio_clk), .bus_rst (bus_rst),
      .i_ctrl_tdata (i_ctrl_tdata), .i_ctrl_tlast (i_ctrl_tlast),
      .i_ctrl_tvalid (i_ctrl_tvalid), .o_ctrl_tready (o_ctrl_tready),
      .o_resp_tdata (o_resp_tdata), .o_resp_tlast (o_resp_tlast),
      .o_resp_tvalid (o_resp_tvalid), .i_resp_tready (i_resp_tready),
      .i_rb_misc (i_rb_misc), .i_lock (i_lock),
      .i_pps_int (i_pps_int), .i_pps_ext (i_pps_ext),
      .o_misc_outs (o_misc_outs), .o_pps (o_pps), .o_time_sync (o_time_sync)
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         abort_run($sformatf("error: %s is 0x%h, expected 0x%h", name, actual, expected));
      end
   endtask

   function automatic logic [63:0] header_word(input logic [7:0] dst, input logic [7:0] src,
                                               input logic [11:0] seq);
      ctrl_word_u w;
      w = '0;
      w.hdr.seqnum  = seq;
      w.hdr.src_sid = src;
      w.hdr.dst_sid = dst;
      return w;
   endfunction

   function automatic logic [63:0] cmd_word(input logic [7:0] addr, input logic [31:0] data);
      ctrl_word_u w;
      w = '0;
      w.cmd.addr = addr;
      w.cmd.data = data;
      return w;
   endfunction

   // one request row, fields in table order
   task automatic add_row(input logic [7:0] dst, input logic [7:0] src,
                          input logic [11:0] seq, input logic [7:0] addr,
                          input logic [31:0] data, input logic resp,
                          input logic extra, input logic [63:0] rb);
      rows.push_back({dst, src, seq, addr, data, resp, extra, rb});
   endtask

   // called on a falling edge, returns on the falling edge after the transfer
   task automatic send_word(input logic [63:0] data, input logic last);
      i_ctrl_tdata  = data;
      i_ctrl_tlast  = last;
      i_ctrl_tvalid = 1'b1;
      while (!o_ctrl_tready) @(negedge radio_clk);
      @(negedge radio_clk);
      i_ctrl_tvalid = 1'b0;
   endtask

   task automatic send_row(input req_row_t row, input int idx);
      logic [63:0] filler;
      filler = {16'hBAD0, 16'(idx), 32'h5A5A5A5A};
      // response swaps the stream IDs
      if (row.resp_exp) begin
         exp_q.push_back({1'b0, header_word(row.src_sid, row.dst_sid, row.seqnum)});
         exp_q.push_back({1'b1, row.exp_rb});
      end
      send_word(header_word(row.dst_sid, row.src_sid, row.seqnum), 1'b0);
      send_word(cmd_word(row.addr, row.data), !row.extra);
      if (row.extra) send_word(filler, 1'b1);
   endtask

   task automatic wait_responses();
      while (exp_q.size() != 0) @(negedge radio_clk);
   endtask

   task automatic pulse_to_pps(input logic use_ext);
      if (use_ext) i_pps_ext = 1'b1;
      else i_pps_int = 1'b1;
      check_value("o_pps", o_pps, 0);
      @(negedge radio_clk);
      i_pps_int = 1'b0;
      i_pps_ext = 1'b0;
      check_value("o_pps", o_pps, 0);
      @(negedge radio_clk);
      check_value("o_pps", o_pps, 1);
      @(negedge radio_clk);
      check_value("o_pps", o_pps, 0);
   endtask

   task automatic measure_pps_period();
      int gap;
      while (!o_pps) @(negedge radio_clk);
      @(negedge radio_clk);
      gap = 1;
      check_value("o_pps", o_pps, 0);
      while (!o_pps) begin
         @(negedge radio_clk);
         gap++;
      end
      check_value("o_pps period", gap, pps_period);
   endtask

   // both external sources pulse, output must stay quiet
   task automatic watch_pps_low();
      int n;
      n = 0;
      repeat (pps_period + 4) begin
         i_pps_int = (n % 50) == 0;
         i_pps_ext = (n % 50) == 25;
         check_value("o_pps", o_pps, 0);
         @(negedge radio_clk);
         n++;
      end
      i_pps_int = 1'b0;
      i_pps_ext = 1'b0;
   endtask

   task automatic check_pps(input logic [1:0] sel);
      case (sel)
         2'd0: pulse_to_pps(1'b0);
         2'd1: pulse_to_pps(1'b1);
         2'd2: measure_pps_period();
         default: watch_pps_low();
      endcase
   endtask

   // response receiver with random back-pressure
   always @(negedge radio_clk) begin : resp_receiver
      if (!bus_rst) begin
         i_resp_tready = ($urandom % 3) != 0;
         if (o_resp_tvalid && i_resp_tready) begin
            if (exp_q.size() == 0) begin
               abort_run("response word arrived with no request waiting for it");
            end else begin
               exp_word = exp_q.pop_front();
               check_value("o_resp_tdata", o_resp_tdata, exp_word[63:0]);
               check_value("o_resp_tlast", o_resp_tlast, exp_word[64]);
            end
         end
      end
   end

   always @(posedge radio_clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         abort_run($sformatf("timeout, run did not finish within %0d cycles", cycle_limit));
      end
   end

   initial begin
      void'($urandom(47));
      i_ctrl_tdata  = '0;
      i_ctrl_tlast  = 1'b0;
      i_ctrl_tvalid = 1'b0;
      i_resp_tready = 1'b0;
      i_rb_misc     = $urandom;
      i_lock        = 2'b10;
      i_pps_int     = 1'b0;
      i_pps_ext     = 1'b0;
      misc_model    = '0;

      sig_word   = {rb_signature, compat_major, compat_minor};
      misc1_word = {32'h0, 32'hDEADBEEF};
      misc2_word = {32'h0, 32'h0F0F0001};
      gps_word   = {16'h0, radio_status, 8'hA5, i_rb_misc};
      lock_word  = {62'h0, i_lock};

      // dst, src, seqnum, addr, data, response, third word, readback
      add_row(8'h40, 8'h12, 12'h001, sr_core_readback, 32'h0, 1'b1, 1'b0, sig_word);
      add_row(8'h41, 8'h13, 12'h002, sr_core_misc, 32'hDEADBEEF, 1'b1, 1'b0, sig_word);
      add_row(8'h40, 8'h14, 12'h003, sr_core_readback, 32'h1, 1'b1, 1'b0, misc1_word);
      add_row(8'h50, 8'h15, 12'h004, sr_core_misc, 32'h12345678, 1'b0, 1'b0, 64'h0);
      add_row(8'h4F, 8'h16, 12'h005, sr_core_readback, 32'h1, 1'b1, 1'b1, misc1_word);
      add_row(8'h40, 8'h17, 12'h006, sr_core_gpsdo_st, 32'hA5, 1'b1, 1'b0, misc1_word);
      add_row(8'h40, 8'h18, 12'h007, sr_core_readback, 32'h2, 1'b1, 1'b0, gps_word);
      add_row(8'h40, 8'h19, 12'h008, sr_core_readback, 32'h3, 1'b1, 1'b0, lock_word);
      add_row(8'h80, 8'h1A, 12'h009, sr_core_readback, 32'h0, 1'b0, 1'b1, 64'h0);
      add_row(8'h40, 8'h1B, 12'h00A, sr_core_misc, 32'h0F0F0001, 1'b1, 1'b0, lock_word);
      add_row(8'h40, 8'h1C, 12'h00B, sr_core_readback, 32'h5, 1'b1, 1'b0, 64'h0);
      add_row(8'h40, 8'h1D, 12'h00C, sr_core_sync, 32'h4, 1'b1, 1'b0, 64'h0);
      add_row(8'h40, 8'h1E, 12'h00D, sr_core_sync, 32'h1, 1'b1, 1'b0, 64'h0);
      add_row(8'h40, 8'h1F, 12'h00E, sr_core_sync, 32'h6, 1'b1, 1'b0, 64'h0);
      add_row(8'h40, 8'h20, 12'h00F, sr_core_sync, 32'h3, 1'b1, 1'b1, 64'h0);
      add_row(8'h40, 8'h21, 12'hFFF, sr_core_readback, 32'h1, 1'b1, 1'b0, misc2_word);
      cycle_limit = rows.size() * 40 + 4 * pps_period;

      @(negedge radio_clk);
      while (bus_rst) @(negedge radio_clk);
      check_value("o_resp_tvalid", o_resp_tvalid, 0);
      check_value("o_misc_outs", o_misc_outs, 0);
      check_value("o_time_sync", o_time_sync, 0);

      ////////////////////////////////////////
      // request table
      ////////////////////////////////////////
      for (row_idx = 0; row_idx < rows.size(); row_idx++) begin
         send_row(rows[row_idx], row_idx);
         if (rows[row_idx].resp_exp) begin
            wait_responses();
            if (rows[row_idx].addr == sr_core_misc) misc_model = rows[row_idx].data;
            check_value("o_misc_outs", o_misc_outs, misc_model);
            if (rows[row_idx].addr == sr_core_sync) begin
               check_value("o_time_sync", o_time_sync, rows[row_idx].data[2]);
               check_pps(rows[row_idx].data[1:0]);
            end
         end
      end

      wait_responses();
      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== core_assert.sv ====
////////////////////////////////////////
// response stream and strobe checks
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module core_assert (
   input wire                             radio_clk,
   input wire                             bus_rst,
   input wire [core_pkg::ctrl_width-1:0]  i_resp_tdata,
   input wire                             i_resp_tvalid,
   input wire                             i_resp_tready,
   input wire                             i_stb
);

   // stalled word stays on the bus unchanged
   stall_hold: assert property (@(posedge radio_clk) disable iff (bus_rst)
      (i_resp_tvalid && !i_resp_tready) |=> (i_resp_tvalid && $stable(i_resp_tdata)))
      else $error("response word changed while stalled");

   reset_idle: assert property (@(posedge radio_clk) bus_rst |=> !i_resp_tvalid)
      else $error("response valid high during reset");

   // one write per request
   stb_single: assert property (@(posedge radio_clk) disable iff (bus_rst)
      i_stb |=> !i_stb)
      else $error("settings strobe high for two cycles");

endmodule

bind ctrl_proc core_assert core_assert_i (
   .radio_clk     (radio_clk),
   .bus_rst       (bus_rst),
   .i_resp_tdata  (o_resp_tdata),
   .i_resp_tvalid (o_resp_tvalid),
   .i_resp_tready (i_resp_tready),
   .i_stb         (sbus.stb)
);

`default_nettype wire

// ==== tb_clock_gen.sv ====
////////////////////////////////////////
// testbench clock and reset
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
   output logic radio_clk,
   output logic bus_rst
);

   // 40 ns period
   initial begin
      radio_clk = 1'b0;
      forever #20 radio_clk = ~radio_clk;
   end

   // reset held for 8 cycles, released on a falling edge
   initial begin
      bus_rst = 1'b1;
      repeat (8) @(posedge radio_clk);
      @(negedge radio_clk);
      bus_rst = 1'b0;
   end

endmodule

`default_nettype wire

// ==== core_top.sv ====
////////////////////////////////////////
// radio core control plane top
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module core_top (
   input  wire                                 radio_clk,
   input  wire                                 bus_rst,
   // control request stream
   input  wire [core_pkg::ctrl_width-1:0]      i_ctrl_tdata,
   input  wire                                 i_ctrl_tlast,
   input  wire                                 i_ctrl_tvalid,
   output logic                                o_ctrl_tready,
   // control response stream
   output logic [core_pkg::ctrl_width-1:0]     o_resp_tdata,
   output logic                                o_resp_tlast,
   output logic                                o_resp_tvalid,
   input  wire                                 i_resp_tready,
   // status and misc
   input  wire [core_pkg::sr_data_width-1:0]   i_rb_misc,
   input  wire [1:0]                           i_lock,
   input  wire                                 i_pps_int,
   input  wire                                 i_pps_ext,
   output logic [core_pkg::sr_data_width-1:0]  o_misc_outs,
   output logic                                o_pps,
   output logic                                o_time_sync
);

   logic [1:0] pps_sel;

   ctrl_stream_if filt_to_proc ();
   settings_if    sbus ();

   ctrl_sid_filter ctrl_sid_filter_i (
      .radio_clk (radio_clk),
      .bus_rst   (bus_rst),
      .i_tdata   (i_ctrl_tdata),
      .i_tlast   (i_ctrl_tlast),
      .i_tvalid  (i_ctrl_tvalid),
      .o_tready  (o_ctrl_tready),
      .m_out     (filt_to_proc)
   );

   ctrl_proc ctrl_proc_i (
      .radio_clk     (radio_clk),
      .bus_rst       (bus_rst),
      .s_in          (filt_to_proc),
      .sbus          (sbus),
      .o_resp_tdata  (o_resp_tdata),
      .o_resp_tlast  (o_resp_tlast),
      .o_resp_tvalid (o_resp_tvalid),
      .i_resp_tready (i_resp_tready)
   );

   core_settings core_settings_i (
      .radio_clk   (radio_clk),
      .bus_rst     (bus_rst),
      .sbus        (sbus),
      .i_rb_misc   (i_rb_misc),
      .i_lock      (i_lock),
      .o_misc_outs (o_misc_outs),
      .o_pps_sel   (pps_sel),
      .o_time_sync (o_time_sync)
   );

   pps_select pps_select_i (
      .radio_clk (radio_clk),
      .bus_rst   (bus_rst),
      .i_pps_int (i_pps_int),
      .i_pps_ext (i_pps_ext),
      .i_pps_sel (pps_sel),
      .o_pps     (o_pps)
   );

endmodule

`default_nettype wire

// ==== pps_select.sv ====
////////////////////////////////////////
// PPS source select
// synchronisers, internal PPS and source mux
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module pps_select (
   input  wire        radio_clk,
   input  wire        bus_rst,
   input  wire        i_pps_int,
   input  wire        i_pps_ext,
   input  wire [1:0]  i_pps_sel,
   output logic       o_pps
);
   import core_pkg::*;

   logic [pps_cnt_width-1:0] pps_cnt;
   logic                     pps_gen;
   logic [2:0]               pps_s1;
   logic [2:0]               pps_s2;

   // internal pps, one pulse per period
   always_ff @(posedge radio_clk) begin
      if (bus_rst) begin
         pps_cnt <= '0;
         pps_gen <= 1'b0;
      end else if (pps_cnt == pps_cnt_width'(pps_period - 1)) begin
         pps_cnt <= '0;
         pps_gen <= 1'b1;
      end else begin
         pps_cnt <= pps_cnt + 1'b1;
         pps_gen <= 1'b0;
      end
   end

   // bit 0 gpsdo, bit 1 external, bit 2 internal
   always_ff @(posedge radio_clk) begin
      if (bus_rst) begin
         pps_s1 <= '0;
         pps_s2 <= '0;
      end else begin
         pps_s1 <= {pps_gen, i_pps_ext, i_pps_int};
         pps_s2 <= pps_s1;
      end
   end

   always_comb begin
      case (i_pps_sel)
         2'd0: o_pps = pps_s2[0];
         2'd1: o_pps = pps_s2[1];
         2'd2: o_pps = pps_s2[2];
         default: o_pps = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// ==== core_settings.sv ====
////////////////////////////////////////
// core setting registers
// lock synchroniser and readback mux
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module core_settings (
   input  wire                                 radio_clk,
   input  wire                                 bus_rst,
   settings_if.slave                           sbus,
   input  wire [core_pkg::sr_data_width-1:0]   i_rb_misc,
   input  wire [1:0]                           i_lock,
   output logic [core_pkg::sr_data_width-1:0]  o_misc_outs,
   output logic [1:0]                          o_pps_sel,
   output logic                                o_time_sync
);
   import core_pkg::*;

   logic [sr_data_width-1:0] misc_reg;
   logic [2:0]               rb_sel;
   logic [7:0]               gpsdo_st;
   logic [2:0]               sync_reg;
   logic [1:0]               lock_s1;
   logic [1:0]               lock_s2;
   logic                     wr_misc;
   logic                     wr_rb;
   logic                     wr_gpsdo;
   logic                     wr_sync;

   // address decode
   assign wr_misc  = sbus.stb && (sbus.addr == sr_core_misc);
   assign wr_rb    = sbus.stb && (sbus.addr == sr_core_readback);
   assign wr_gpsdo = sbus.stb && (sbus.addr == sr_core_gpsdo_st);
   assign wr_sync  = sbus.stb && (sbus.addr == sr_core_sync);

   always_ff @(posedge radio_clk) begin
      if (bus_rst) begin
         misc_reg <= '0;
         rb_sel   <= '0;
         sync_reg <= '0;
      end else begin
         if (wr_misc) misc_reg <= sbus.data;
         if (wr_rb) rb_sel <= sbus.data[2:0];
         // bit 2 time sync, bits 1..0 pps source
         if (wr_sync) sync_reg <= sbus.data[2:0];
      end
   end

   // gpsdo status keeps its value across reset
   always_ff @(posedge radio_clk) begin
      if (wr_gpsdo) gpsdo_st <= sbus.data[7:0];
   end

   // two-stage lock synchroniser
   always_ff @(posedge radio_clk) begin
      if (bus_rst) begin
         lock_s1 <= '0;
         lock_s2 <= '0;
      end else begin
         lock_s1 <= i_lock;
         lock_s2 <= lock_s1;
      end
   end

   ////////////////////////////////////////
   // readback mux
   ////////////////////////////////////////
   always_comb begin
      case (rb_sel)
         3'd0: sbus.rb_data = {rb_signature, compat_major, compat_minor};
         3'd1: sbus.rb_data = {32'b0, misc_reg};
         3'd2: sbus.rb_data = {16'b0, radio_status, gpsdo_st, i_rb_misc};
         3'd3: sbus.rb_data = {62'b0, lock_s2};
         default: sbus.rb_data = '0;
      endcase
   end

   assign o_misc_outs = misc_reg;
   assign o_pps_sel   = sync_reg[1:0];
   assign o_time_sync = sync_reg[2];

endmodule

`default_nettype wire

// ==== ctrl_proc.sv ====
////////////////////////////////////////
// control processor
// command packet to settings write and response
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ctrl_proc (
   input  wire                              radio_clk,
   input  wire                              bus_rst,
   ctrl_stream_if.sink                      s_in,
   settings_if.master                       sbus,
   output logic [core_pkg::ctrl_width-1:0]  o_resp_tdata,
   output logic                             o_resp_tlast,
   output logic                             o_resp_tvalid,
   input  wire                              i_resp_tready
);
   import core_pkg::*;

   logic [2:0]               state;
   ctrl_word_u               in_word;
   ctrl_word_u               resp_hdr;
   logic [11:0]              seqnum;
   logic [7:0]               req_src_sid;
   logic [7:0]               req_dst_sid;
   logic [sr_addr_width-1:0] cmd_addr;
   logic [sr_data_width-1:0] cmd_data;
   logic                     cmd_last;
   logic [ctrl_width-1:0]    rb_word;
   logic                     in_fire;
   logic                     resp_fire;

   assign in_word     = s_in.tdata;
   assign s_in.tready = (state == st_hdr) || (state == st_cmd) || (state == st_drain);
   assign in_fire     = s_in.tvalid && s_in.tready;
   assign resp_fire   = o_resp_tvalid && i_resp_tready;

   ////////////////////////////////////////
   // FSM
   ////////////////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (bus_rst) begin
         state <= st_hdr;
      end else begin
         case (state)
            st_hdr: if (in_fire && !s_in.tlast) state <= st_cmd;
            st_cmd: if (in_fire) state <= st_write;
            st_write: state <= st_resp_hdr;
            st_resp_hdr: if (resp_fire) state <= st_resp_data;
            // extra request words are drained after the response
            st_resp_data: if (resp_fire) state <= cmd_last ? st_hdr : st_drain;
            st_drain: if (in_fire && s_in.tlast) state <= st_hdr;
            default: state <= st_hdr;
         endcase
      end
   end

   // request fields and readback capture
   always_ff @(posedge radio_clk) begin
      if ((state == st_hdr) && in_fire) begin
         seqnum      <= in_word.hdr.seqnum;
         req_src_sid <= in_word.hdr.src_sid;
         req_dst_sid <= in_word.hdr.dst_sid;
      end
      if ((state == st_cmd) && in_fire) begin
         cmd_addr <= in_word.cmd.addr;
         cmd_data <= in_word.cmd.data;
         cmd_last <= s_in.tlast;
      end
      // write already landed, hold value through stalls
      if ((state == st_resp_hdr) && resp_fire) begin
         rb_word <= sbus.rb_data;
      end
   end

   ////////////////////////////////////////
   // settings write and response
   ////////////////////////////////////////
   assign sbus.stb  = state == st_write;
   assign sbus.addr = cmd_addr;
   assign sbus.data = cmd_data;

   // echo seqnum, swap stream IDs
   always_comb begin
      resp_hdr             = '0;
      resp_hdr.hdr.seqnum  = seqnum;
      resp_hdr.hdr.src_sid = req_dst_sid;
      resp_hdr.hdr.dst_sid = req_src_sid;
   end

   assign o_resp_tvalid = (state == st_resp_hdr) || (state == st_resp_data);
   assign o_resp_tlast  = state == st_resp_data;
   assign o_resp_tdata  = (state == st_resp_data) ? rb_word : resp_hdr;

endmodule

`default_nettype wire

// ==== ctrl_sid_filter.sv ====
////////////////////////////////////////
// control stream ID filter
// passes packets for this core, drops the rest
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ctrl_sid_filter (
   input  wire                             radio_clk,
   input  wire                             bus_rst,
   input  wire [core_pkg::ctrl_width-1:0]  i_tdata,
   input  wire                             i_tlast,
   input  wire                             i_tvalid,
   output logic                            o_tready,
   ctrl_stream_if.source                   m_out
);
   import core_pkg::*;

   ctrl_word_u            in_word;
   logic                  in_hdr;
   logic                  keep_pkt;
   logic                  hdr_match;
   logic                  pass_word;
   logic                  accept;
   logic                  out_valid;
   logic                  out_last;
   logic [ctrl_width-1:0] out_data;

   assign in_word   = i_tdata;
   assign hdr_match = (in_word.hdr.dst_sid & sid_mask) == core_ctrl_sid;
   // header decides, later words follow the stored decision
   assign pass_word = in_hdr ? hdr_match : keep_pkt;

   // room when empty or draining this cycle
   assign o_tready = !out_valid || m_out.tready;
   assign accept   = i_tvalid && o_tready;

   always_ff @(posedge radio_clk) begin
      if (bus_rst) begin
         in_hdr    <= 1'b1;
         keep_pkt  <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         if (accept) begin
            in_hdr <= i_tlast;
            if (in_hdr) begin
               keep_pkt <= hdr_match;
            end
         end
         if (accept && pass_word) begin
            out_valid <= 1'b1;
         end else if (m_out.tready) begin
            out_valid <= 1'b0;
         end
      end
   end

   // output word register
   always_ff @(posedge radio_clk) begin
      if (accept && pass_word) begin
         out_data <= i_tdata;
         out_last <= i_tlast;
      end
   end

   assign m_out.tdata  = out_data;
   assign m_out.tlast  = out_last;
   assign m_out.tvalid = out_valid;

endmodule

`default_nettype wire

// ==== settings_if.sv ====
////////////////////////////////////////
// settings bus interface
// write strobe, address, data and readback
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

interface settings_if;
   import core_pkg::*;

   logic                     stb;
   logic [sr_addr_width-1:0] addr;
   logic [sr_data_width-1:0] data;
   logic [ctrl_width-1:0]    rb_data;

   // write side, readback comes back
   modport master (output stb, output addr, output data, input rb_data);

   // register side
   modport slave (input stb, input addr, input data, output rb_data);

endinterface

`default_nettype wire

// ==== ctrl_stream_if.sv ====
////////////////////////////////////////
// control stream interface
// 64-bit valid/ready/last word stream
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

interface ctrl_stream_if;
   import core_pkg::*;

   logic [ctrl_width-1:0] tdata;
   logic                  tlast;
   logic                  tvalid;
   logic                  tready;

   // upstream side
   modport source (output tdata, output tlast, output tvalid, input tready);

   // downstream side
   modport sink (input tdata, input tlast, input tvalid, output tready);

endinterface

`default_nettype wire

// ==== core_pkg.sv ====
////////////////////////////////////////
// core control plane package
// widths, settings map, stream IDs, word layout
////////////////////////////////////////
`default_nettype none

package core_pkg;

   // bus widths
   localparam int ctrl_width    = 64;
   localparam int sr_addr_width = 8;
   localparam int sr_data_width = 32;

   // settings bus register map
   localparam logic [sr_addr_width-1:0] sr_core_misc     = 8'd16;
   localparam logic [sr_addr_width-1:0] sr_core_readback = 8'd32;
   localparam logic [sr_addr_width-1:0] sr_core_gpsdo_st = 8'd40;
   localparam logic [sr_addr_width-1:0] sr_core_sync     = 8'd48;

   // control stream routing
   localparam logic [7:0] core_ctrl_sid = 8'h40;
   localparam logic [7:0] sid_mask      = 8'hF0;

   // readback fields
   localparam logic [31:0] rb_signature = 32'hACE0BA5E;
   localparam logic [15:0] compat_major = 16'h000E;
   localparam logic [15:0] compat_minor = 16'h0000;
   localparam logic [7:0]  radio_status = 8'd1;

   // internal pps period in clocks, short for simulation
   localparam int pps_period    = 200;
   localparam int pps_cnt_width = $clog2(pps_period);

   // control processor states
   localparam logic [2:0] st_hdr       = 3'd0;
   localparam logic [2:0] st_cmd       = 3'd1;
   localparam logic [2:0] st_drain     = 3'd2;
   localparam logic [2:0] st_write     = 3'd3;
   localparam logic [2:0] st_resp_hdr  = 3'd4;
   localparam logic [2:0] st_resp_data = 3'd5;

   // one stream word, seen as header or as command
   typedef union packed {
      struct packed {
         logic [3:0]  rsvd_hi;
         logic [11:0] seqnum;
         logic [31:0] rsvd_lo;
         logic [7:0]  src_sid;
         logic [7:0]  dst_sid;
      } hdr;
      struct packed {
         logic [ctrl_width-sr_addr_width-sr_data_width-1:0] rsvd;
         logic [sr_addr_width-1:0]                          addr;
         logic [sr_data_width-1:0]                          data;
      } cmd;
   } ctrl_word_u;

endpackage

`default_nettype wire
